// ==== design/ldl_pkg.sv ====
`default_nettype none

package ldl_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // matrix order
    localparam int dim = 4;
    localparam int idx_w = $clog2(dim);

    localparam int word_w = 16;
    typedef logic [word_w-1:0] word_t;

    localparam int addr_w = 5;
    typedef logic [addr_w-1:0] addr_t;

    //////////////////////////////////////////////////
    // work memory map, in words
    //////////////////////////////////////////////////

    // L row-major, unit diagonal implied
    localparam int l_base = 0;
    // diagonal reciprocals
    localparam int dinv_base = 16;
    // b on entry, x on exit
    localparam int w_base = 20;
    localparam int mem_depth = 24;

    //////////////////////////////////////////////////
    // apb registers, byte offsets
    //////////////////////////////////////////////////

    // bit 0 starts a solve
    localparam logic [7:0] reg_ctrl = 8'h80;
    // bit 0 busy, bit 1 done
    localparam logic [7:0] reg_status = 8'h84;

    // sequencer phases
    typedef enum logic [1:0] {
        idle,
        forward,
        scale,
        backward
    } phase_t;

endpackage

`default_nettype wire

// ==== design/mem_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    import ldl_pkg::*;

    // request side, held until gnt
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;

    // return side
    logic  gnt;
    word_t rdata;
    // read data valid, one cycle after a granted read
    logic  rvalid;

    modport master (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

`default_nettype wire

// ==== design/solver_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module solver_mem (
    input  logic          clk,
    input  logic          we,
    input  ldl_pkg::addr_t addr,
    input  ldl_pkg::word_t wdata,
    output ldl_pkg::word_t rdata
);
    import ldl_pkg::*;

    word_t mem [mem_depth];
    logic  in_range;

    // the address space is wider than the array
    assign in_range = (addr < addr_t'(mem_depth));

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we && in_range) begin
            mem[addr] <= wdata;
        end
    end

    //////////////////////////////////////////////////
    // registered read, every cycle
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (in_range) begin
            rdata <= mem[addr];
        end else begin
            // unmapped words read as zero
            rdata <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic           clk,
    input  logic           rst,
    mem_bus_if.arbiter     tri_bus,
    mem_bus_if.arbiter     diag_bus,
    mem_bus_if.arbiter     host_bus,
    output logic           mem_we,
    output ldl_pkg::addr_t mem_addr,
    output ldl_pkg::word_t mem_wdata,
    input  ldl_pkg::word_t mem_rdata
);
    import ldl_pkg::*;

    logic gnt_tri, gnt_diag, gnt_host;
    // which master owns the read now in flight
    logic [2:0] rd_owner;

    // fixed priority: tri, diag, host
    assign gnt_tri  = tri_bus.req;
    assign gnt_diag = diag_bus.req && !tri_bus.req;
    assign gnt_host = host_bus.req && !tri_bus.req && !diag_bus.req;

    assign tri_bus.gnt  = gnt_tri;
    assign diag_bus.gnt = gnt_diag;
    assign host_bus.gnt = gnt_host;

    always_comb begin
        if (gnt_tri) begin
            mem_we    = tri_bus.we;
            mem_addr  = tri_bus.addr;
            mem_wdata = tri_bus.wdata;
        end else if (gnt_diag) begin
            mem_we    = diag_bus.we;
            mem_addr  = diag_bus.addr;
            mem_wdata = diag_bus.wdata;
        end else begin
            // host drives the port when nobody asks, write only on grant
            mem_we    = gnt_host && host_bus.we;
            mem_addr  = host_bus.addr;
            mem_wdata = host_bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_owner <= '0;
        end else begin
            rd_owner <= {gnt_host && !host_bus.we,
                         gnt_diag && !diag_bus.we,
                         gnt_tri && !tri_bus.we};
        end
    end

    // read data goes to everyone, rvalid only to the owner
    assign tri_bus.rdata   = mem_rdata;
    assign diag_bus.rdata  = mem_rdata;
    assign host_bus.rdata  = mem_rdata;
    assign tri_bus.rvalid  = rd_owner[0];
    assign diag_bus.rvalid = rd_owner[1];
    assign host_bus.rvalid = rd_owner[2];

endmodule

`default_nettype wire

// ==== design/tri_solver.sv ====
`timescale 1ns/1ps
`default_nettype none

module tri_solver (
    input  logic      clk,
    input  logic      rst,
    input  logic      fwd_start,
    input  logic      bwd_start,
    output logic      tri_done,
    mem_bus_if.master mem
);
    import ldl_pkg::*;

    typedef enum logic [2:0] {
        t_idle,
        t_rd_wi,
        t_rd_l,
        t_rd_wj,
        t_wr_wi
    } tri_state_t;

    tri_state_t       state;
    logic             waiting;
    logic             bwd;
    logic [idx_w-1:0] i;
    logic [idx_w-1:0] j;
    word_t            acc;
    word_t            lval;
    logic             has_terms;
    logic             last_term;
    logic             last_row;

    // forward walks j below i, backward walks j above i
    assign has_terms = bwd ? (i != idx_w'(dim - 1)) : (i != '0);
    assign last_term = bwd ? (j == idx_w'(dim - 1)) : (j == i - 1'b1);
    assign last_row  = bwd ? (i == '0) : (i == idx_w'(dim - 1));

    //////////////////////////////////////////////////
    // memory request
    //////////////////////////////////////////////////

    always_comb begin
        mem.req   = (state != t_idle) && !waiting;
        mem.we    = (state == t_wr_wi);
        mem.wdata = acc;
        case (state)
            // backward reads L transposed, so by columns
            t_rd_l:  mem.addr = bwd ? addr_t'(l_base + j * dim + i)
                                    : addr_t'(l_base + i * dim + j);
            t_rd_wj: mem.addr = addr_t'(w_base + j);
            default: mem.addr = addr_t'(w_base + i);
        endcase
    end

    //////////////////////////////////////////////////
    // row loop
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= t_idle;
            waiting  <= 1'b0;
            tri_done <= 1'b0;
            bwd      <= 1'b0;
            i        <= '0;
            j        <= '0;
        end else begin
            tri_done <= 1'b0;
            // a granted read waits one cycle for its data
            if (mem.gnt && state != t_wr_wi) begin
                waiting <= 1'b1;
            end
            if (mem.rvalid) begin
                waiting <= 1'b0;
            end
            case (state)
                t_idle: begin
                    if (fwd_start || bwd_start) begin
                        bwd   <= bwd_start;
                        i     <= bwd_start ? idx_w'(dim - 1) : '0;
                        state <= t_rd_wi;
                    end
                end
                t_rd_wi: begin
                    if (mem.rvalid) begin
                        acc   <= mem.rdata;
                        j     <= bwd ? i + 1'b1 : '0;
                        state <= has_terms ? t_rd_l : t_wr_wi;
                    end
                end
                t_rd_l: begin
                    if (mem.rvalid) begin
                        lval  <= mem.rdata;
                        state <= t_rd_wj;
                    end
                end
                t_rd_wj: begin
                    if (mem.rvalid) begin
                        acc <= word_t'(acc - lval * mem.rdata);
                        if (last_term) begin
                            state <= t_wr_wi;
                        end else begin
                            j     <= j + 1'b1;
                            state <= t_rd_l;
                        end
                    end
                end
                t_wr_wi: begin
                    if (mem.gnt) begin
                        if (last_row) begin
                            tri_done <= 1'b1;
                            state    <= t_idle;
                        end else begin
                            i     <= bwd ? i - 1'b1 : i + 1'b1;
                            state <= t_rd_wi;
                        end
                    end
                end
                default: state <= t_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/diag_scaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module diag_scaler (
    input  logic      clk,
    input  logic      rst,
    input  logic      scale_start,
    output logic      scale_done,
    mem_bus_if.master mem
);
    import ldl_pkg::*;

    typedef enum logic [1:0] {
        d_idle,
        d_rd_w,
        d_rd_d,
        d_wr
    } diag_state_t;

    diag_state_t      state;
    logic             waiting;
    logic [idx_w-1:0] i;
    // holds w[i], then the scaled value
    word_t            acc;

    assign mem.req   = (state != d_idle) && !waiting;
    assign mem.we    = (state == d_wr);
    assign mem.wdata = acc;
    assign mem.addr  = (state == d_rd_d) ? addr_t'(dinv_base + i) : addr_t'(w_base + i);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= d_idle;
            waiting    <= 1'b0;
            scale_done <= 1'b0;
            i          <= '0;
        end else begin
            scale_done <= 1'b0;
            if (mem.gnt && state != d_wr) begin
                waiting <= 1'b1;
            end
            if (mem.rvalid) begin
                waiting <= 1'b0;
            end
            case (state)
                d_idle: begin
                    if (scale_start) begin
                        i     <= '0;
                        state <= d_rd_w;
                    end
                end
                d_rd_w: begin
                    if (mem.rvalid) begin
                        acc   <= mem.rdata;
                        state <= d_rd_d;
                    end
                end
                d_rd_d: begin
                    if (mem.rvalid) begin
                        // low half of the product only
                        acc   <= word_t'(acc * mem.rdata);
                        state <= d_wr;
                    end
                end
                d_wr: begin
                    if (mem.gnt) begin
                        if (i == idx_w'(dim - 1)) begin
                            scale_done <= 1'b1;
                            state      <= d_idle;
                        end else begin
                            i     <= i + 1'b1;
                            state <= d_rd_w;
                        end
                    end
                end
                default: state <= d_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_port (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        done,
    mem_bus_if.master   mem,
    output logic        fwd_start,
    output logic        bwd_start,
    output logic        scale_start,
    input  logic        tri_done,
    input  logic        scale_done
);
    import ldl_pkg::*;

    typedef enum logic [1:0] {
        h_idle,
        h_req,
        h_rd_wait
    } host_state_t;

    host_state_t hstate;
    phase_t      phase;
    logic        is_mem;
    logic        busy;
    logic        start_wr;

    assign is_mem   = !paddr[7];
    assign busy     = (phase != idle);
    assign start_wr = psel && penable && pwrite && (paddr == reg_ctrl) && pwdata[0];

    //////////////////////////////////////////////////
    // apb decode
    //////////////////////////////////////////////////

    // address and data stay stable through the access phase
    assign mem.req   = (hstate == h_req);
    assign mem.we    = pwrite;
    assign mem.addr  = addr_t'(paddr[addr_w+1:2]);
    assign mem.wdata = pwdata[word_w-1:0];

    assign pready  = is_mem ? ((hstate == h_req && mem.gnt && pwrite) ||
                               (hstate == h_rd_wait && mem.rvalid))
                            : (psel && penable);
    assign pslverr = psel && penable && (paddr > reg_status);
    assign prdata  = is_mem ? {{(32 - word_w){1'b0}}, mem.rdata}
                   : (paddr == reg_status) ? {30'b0, done, busy} : '0;

    // request goes out from the setup cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            hstate <= h_idle;
        end else begin
            case (hstate)
                h_idle:    if (psel && !penable && is_mem) hstate <= h_req;
                h_req:     if (mem.gnt) hstate <= pwrite ? h_idle : h_rd_wait;
                h_rd_wait: if (mem.rvalid) hstate <= h_idle;
                default:   hstate <= h_idle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // phase sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= idle;
            done        <= 1'b0;
            fwd_start   <= 1'b0;
            scale_start <= 1'b0;
            bwd_start   <= 1'b0;
        end else begin
            fwd_start   <= 1'b0;
            scale_start <= 1'b0;
            bwd_start   <= 1'b0;
            case (phase)
                idle: if (start_wr) begin
                    phase     <= forward;
                    fwd_start <= 1'b1;
                    done      <= 1'b0;
                end
                forward: if (tri_done) begin
                    phase       <= scale;
                    scale_start <= 1'b1;
                end
                scale: if (scale_done) begin
                    phase     <= backward;
                    bwd_start <= 1'b1;
                end
                backward: if (tri_done) begin
                    phase <= idle;
                    done  <= 1'b1;
                end
                default: phase <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/ldl_solve_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ldl_solve_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        done
);
    import ldl_pkg::*;

    logic  fwd_start;
    logic  bwd_start;
    logic  scale_start;
    logic  tri_done;
    logic  scale_done;
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;

    //////////////////////////////////////////////////
    // one link per memory master
    //////////////////////////////////////////////////

    mem_bus_if host_bus ();
    mem_bus_if tri_bus ();
    mem_bus_if diag_bus ();

    host_port host_port_i (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .done        (done),
        .mem         (host_bus.master),
        .fwd_start   (fwd_start),
        .bwd_start   (bwd_start),
        .scale_start (scale_start),
        .tri_done    (tri_done),
        .scale_done  (scale_done)
    );

    tri_solver tri_solver_i (
        .clk       (clk),
        .rst       (rst),
        .fwd_start (fwd_start),
        .bwd_start (bwd_start),
        .tri_done  (tri_done),
        .mem       (tri_bus.master)
    );

    diag_scaler diag_scaler_i (
        .clk         (clk),
        .rst         (rst),
        .scale_start (scale_start),
        .scale_done  (scale_done),
        .mem         (diag_bus.master)
    );

    mem_arbiter mem_arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .tri_bus   (tri_bus.arbiter),
        .diag_bus  (diag_bus.arbiter),
        .host_bus  (host_bus.arbiter),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    solver_mem solver_mem_i (
        .clk   (clk),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== sim/ldl_solve_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

// bit 0 tri, bit 1 diag, bit 2 host
module ldl_solve_chk (
    input logic       clk,
    input logic       rst,
    input logic [2:0] req,
    input logic [2:0] we,
    input logic [2:0] gnt,
    input logic [2:0] rvalid
);

    // assertion failures so far
    int fail_count = 0;

    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt))
        else begin
            $error("more than one master granted in the same cycle");
            fail_count++;
        end

    grant_to_requester: assert property (@(posedge clk) disable iff (rst)
        (gnt & ~req) == 3'b000)
        else begin
            $error("grant given to a master that did not request");
            fail_count++;
        end

    // read data marked valid exactly one cycle after a granted read
    rvalid_after_read: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> rvalid == $past(gnt & ~we))
        else begin
            $error("rvalid does not follow a granted read by one cycle");
            fail_count++;
        end

    req_held: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> ($past(req & ~gnt) & ~req) == 3'b000)
        else begin
            $error("request dropped before it was granted");
            fail_count++;
        end

endmodule

bind mem_arbiter ldl_solve_chk ldl_solve_chk_i (
    .clk    (clk),
    .rst    (rst),
    .req    ({host_bus.req, diag_bus.req, tri_bus.req}),
    .we     ({host_bus.we, diag_bus.we, tri_bus.we}),
    .gnt    ({host_bus.gnt, diag_bus.gnt, tri_bus.gnt}),
    .rvalid ({host_bus.rvalid, diag_bus.rvalid, tri_bus.rvalid})
);

`default_nettype wire

// ==== sim/ldl_solve_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ldl_solve_tb;
    import ldl_pkg::*;

    localparam int seed          = 76;
    localparam int apb_timeout   = 50;
    localparam int solve_timeout = 2000;
    localparam int run_count     = 3;
    localparam int busy_starts   = 18;

    logic        clk = 1'b0;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        done;

    // host copy of the problem and the expected solution
    word_t l_mat    [dim * dim];
    word_t dinv_vec [dim];
    word_t b_vec    [dim];
    word_t x_exp    [dim];

    always #50 clk = ~clk;

    ldl_solve_top ldl_solve_top_i (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .done    (done)
    );

    //////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_failure($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    function automatic logic [7:0] byte_addr(input int word_addr);
        return 8'(word_addr * 4);
    endfunction

    // arbiter assertions from the bound checker
    always @(negedge clk) begin
        assert (ldl_solve_top_i.mem_arbiter_i.ldl_solve_chk_i.fail_count == 0)
        else report_failure("an assertion on the memory arbiter failed");
    end

    //////////////////////////////////////////////////
    // apb master
    //////////////////////////////////////////////////

    // waits for pready, then closes the transfer on the next edge
    task automatic finish_access(output logic [31:0] data, output logic err);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!pready && cycles < apb_timeout) begin
            cycles++;
            @(negedge clk);
        end
        assert (pready) else report_failure("timeout waiting for pready");
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd_ignored;
        logic        err;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        finish_access(rd_ignored, err);
        check_equal("pslverr", err, exp_err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err);
        logic err;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        finish_access(data, err);
        check_equal("pslverr", err, exp_err);
    endtask

    //////////////////////////////////////////////////
    // stimulus and model
    //////////////////////////////////////////////////

    task automatic check_memory_rw();
        word_t       image [mem_depth];
        logic [31:0] rd;
        for (int a = 0; a < mem_depth; a++) begin
            image[a] = word_t'($urandom);
            // upper half of pwdata is dropped
            apb_write(byte_addr(a), {word_t'($urandom), image[a]}, 1'b0);
        end
        for (int a = 0; a < mem_depth; a++) begin
            apb_read(byte_addr(a), rd, 1'b0);
            check_equal($sformatf("prdata (word %0d)", a), rd, {16'h0, image[a]});
        end
    endtask

    // all 16 L words random, the solver must ignore the diagonal and above
    task automatic load_problem();
        for (int k = 0; k < dim * dim; k++) begin
            l_mat[k] = word_t'($urandom);
            apb_write(byte_addr(l_base + k), {16'h0, l_mat[k]}, 1'b0);
        end
        for (int k = 0; k < dim; k++) begin
            dinv_vec[k] = word_t'($urandom);
            b_vec[k]    = word_t'($urandom);
            apb_write(byte_addr(dinv_base + k), {16'h0, dinv_vec[k]}, 1'b0);
            apb_write(byte_addr(w_base + k), {16'h0, b_vec[k]}, 1'b0);
        end
    endtask

    task automatic compute_expected();
        word_t acc;
        for (int i = 0; i < dim; i++) begin
            x_exp[i] = b_vec[i];
        end
        // forward, unit diagonal
        for (int i = 0; i < dim; i++) begin
            acc = x_exp[i];
            for (int j = 0; j < i; j++) begin
                acc = acc - l_mat[i * dim + j] * x_exp[j];
            end
            x_exp[i] = acc;
        end
        for (int i = 0; i < dim; i++) begin
            x_exp[i] = x_exp[i] * dinv_vec[i];
        end
        // backward over L transposed
        for (int i = dim - 1; i >= 0; i--) begin
            acc = x_exp[i];
            for (int j = i + 1; j < dim; j++) begin
                acc = acc - l_mat[j * dim + i] * x_exp[j];
            end
            x_exp[i] = acc;
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < solve_timeout) begin
            cycles++;
            @(negedge clk);
        end
        assert (done) else report_failure("timeout waiting for done to rise");
    endtask

    task automatic check_result();
        logic [31:0] rd;
        for (int k = 0; k < dim; k++) begin
            apb_read(byte_addr(w_base + k), rd, 1'b0);
            check_equal($sformatf("prdata (w[%0d])", k), rd, {16'h0, x_exp[k]});
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] rd;
        int          k;
        rd = $urandom(seed);
        rst     <= 1'b1;
        paddr   <= '0;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        pwdata  <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_equal("done", done, 1'b0);
        apb_read(reg_status, rd, 1'b0);
        check_equal("prdata (status)", rd, 32'h0);

        check_memory_rw();

        for (int run = 0; run < run_count; run++) begin
            load_problem();
            compute_expected();
            // done from the previous solve is still set
            @(negedge clk);
            check_equal("done", done, run > 0);
            apb_write(reg_ctrl, 32'h1, 1'b0);
            @(negedge clk);
            check_equal("done", done, 1'b0);
            apb_read(reg_status, rd, 1'b0);
            check_equal("prdata (status)", rd, 32'h1);
            // start again while busy, on into the scale phase, must have no effect
            for (int n = 0; n < busy_starts; n++) begin
                apb_write(reg_ctrl, 32'h1, 1'b0);
            end
            k = $urandom_range(dim * dim - 1);
            apb_read(byte_addr(l_base + k), rd, 1'b0);
            check_equal("prdata (L during solve)", rd, {16'h0, l_mat[k]});
            wait_for_done();
            check_result();
            apb_read(reg_status, rd, 1'b0);
            check_equal("prdata (status)", rd, 32'h2);
            check_equal("done", done, 1'b1);
        end

        // offsets past the status register
        apb_read(8'h88, rd, 1'b1);
        apb_write(8'hfc, 32'h1, 1'b1);
        check_equal("done", done, 1'b1);

        // the checker sees the last cycle too
        @(negedge clk);
        if (ldl_solve_top_i.mem_arbiter_i.ldl_solve_chk_i.fail_count != 0) begin
            report_failure("an assertion on the memory arbiter failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/ldl_pkg.sv
design/mem_bus_if.sv
design/solver_mem.sv
design/mem_arbiter.sv
design/tri_solver.sv
design/diag_scaler.sv
design/host_port.sv
design/ldl_solve_top.sv
sim/ldl_solve_chk.sv
sim/ldl_solve_tb.sv

// ==== Bender.yml ====
package:
  name: ldl_solve

sources:
  - files:
      - design/ldl_pkg.sv
      - design/mem_bus_if.sv
      - design/solver_mem.sv
      - design/mem_arbiter.sv
      - design/tri_solver.sv
      - design/diag_scaler.sv
      - design/host_port.sv
      - design/ldl_solve_top.sv
  - target: simulation
    files:
      - sim/ldl_solve_chk.sv
      - sim/ldl_solve_tb.sv
